// File: dinoGeometryPkg.sv
package dinoGeometryPkg;

    // Screen coordinates are unsigned bytes
    // X grows to the right, Y grows downward
    localparam int coordW = 8;

    // Y of the ground line
    localparam int groundTop = 200;

    // Dinosaur sprite
    localparam int dinoH = 20;
    // Fixed horizontal span, dino never moves in X
    localparam int dinoLeft = 20;
    localparam int dinoRight = 40;

    // Obstacle sprite
    localparam int obsW = 8;
    // Height is minObsH plus a 4-bit random value
    localparam int minObsH = 10;
    // X where a lane reappears after leaving the screen
    localparam int spawnX = 254;

    // Jump arc length in entries
    localparam int jumpSteps = 16;

    // Elevation above ground per arc entry
    // Rough parabola, symmetric around the apex of 47
    // First and last entries sit on the ground
    localparam logic [coordW-1:0] jumpArc [jumpSteps] = '{
        8'd0,  8'd12, 8'd22, 8'd31,
        8'd38, 8'd43, 8'd46, 8'd47,
        8'd47, 8'd46, 8'd43, 8'd38,
        8'd31, 8'd22, 8'd12, 8'd0
    };

endpackage

// File: dinoGameCtrlPkg.sv
package dinoGameCtrlPkg;

    import dinoGeometryPkg::*;

    // Game state input, driven by the menu logic outside the core
    localparam int stateW = 4;
    // Menu clears everything
    localparam logic [stateW-1:0] gameMenu = 4'd0;
    localparam logic [stateW-1:0] gameRunning = 4'd1;
    // Every other code pauses the game

    // Score display, ones digit at index 0
    localparam int scoreDigits = 6;

    // Speed levels, the tick period is tickBase * (4 - level)
    localparam int speedW = 2;
    localparam logic [speedW-1:0] speedSlow = 2'd1;
    localparam logic [speedW-1:0] speedMid = 2'd2;
    localparam logic [speedW-1:0] speedFast = 2'd3;

    // Lanes that have start entries below
    localparam int maxLanes = 2;

    // Lane positions after reset or menu
    // Lane 1 starts halfway so the two lanes stay spread out
    localparam logic [coordW-1:0] laneStartX [maxLanes] = '{
        coordW'(spawnX),
        8'd128
    };

    // Lane heights after reset or menu
    localparam logic [coordW-1:0] laneStartH [maxLanes] = '{
        coordW'(minObsH),
        8'd25
    };

endpackage

// File: moveTicker.sv
`timescale 1ns/10ps

module moveTicker
    import dinoGameCtrlPkg::*;
#(
    parameter int tickBase = 86654
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [stateW-1:0] gameState,
    input  logic [speedW-1:0] speedLevel,
    output logic              moveTick
);

    // Wide enough for the slowest possible period
    localparam int cntW = $clog2(4 * tickBase + 1);

    logic [cntW-1:0] cycleCnt;
    logic [cntW-1:0] period;

    // Faster levels shorten the period
    assign period = cntW'(tickBase * (4 - int'(speedLevel)));

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            cycleCnt <= '0;
            moveTick <= 1'b0;
        end else if (gameState == gameRunning) begin
            // Greater-or-equal catches a count left above a newly shortened period
            if (cycleCnt >= period - cntW'(1)) begin
                cycleCnt <= '0;
                moveTick <= 1'b1;
            end else begin
                cycleCnt <= cycleCnt + cntW'(1);
                moveTick <= 1'b0;
            end
        end
        // Paused, count and a pending tick both wait for the resume
    end

endmodule

// File: obstacleLane.sv
`timescale 1ns/10ps

module obstacleLane
    import dinoGeometryPkg::*;
    import dinoGameCtrlPkg::*;
#(
    parameter int laneIndex = 0
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [stateW-1:0] gameState,
    input  logic              moveTick,
    output logic [coordW-1:0] obsX,
    output logic [coordW-1:0] obsH
);

    // Height generator
    logic [3:0] lfsr;
    logic [3:0] lfsrNext;
    logic       feedback;

    // Taps on bits 2 and 0, inverted so the all-zero state is legal
    assign feedback = ~(lfsr[2] ^ lfsr[0]);
    assign lfsrNext = {lfsr[2:0], feedback};

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            obsX <= laneStartX[laneIndex];
            obsH <= laneStartH[laneIndex];
            lfsr <= 4'd0;
        end else if (gameState == gameRunning && moveTick) begin
            if (obsX == '0) begin
                // Left the screen
                // Come back at the right edge with a new height
                obsX <= coordW'(spawnX);
                lfsr <= lfsrNext;
                obsH <= coordW'(minObsH) + coordW'(lfsrNext);
            end else begin
                // One pixel left per tick
                obsX <= obsX - coordW'(1);
            end
        end
        // No tick or paused, lane stays put
    end

endmodule

// File: jumpController.sv
`timescale 1ns/10ps

module jumpController
    import dinoGeometryPkg::*;
    import dinoGameCtrlPkg::*;
#(
    parameter int jumpStepCycles = 137000
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [stateW-1:0] gameState,
    input  logic              jump,
    output logic [coordW-1:0] dinoY
);

    localparam int idxW = $clog2(jumpSteps);
    localparam int stepW = $clog2(jumpStepCycles + 1);
    // Top of the sprite when standing on the ground
    localparam logic [coordW-1:0] groundY = coordW'(groundTop - dinoH);

    logic [idxW-1:0]  arcIdx;
    logic [stepW-1:0] stepCnt;
    logic             active;
    logic             running;
    logic             stepDone;

    assign running = (gameState == gameRunning);
    assign stepDone = (stepCnt == stepW'(jumpStepCycles - 1));

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            arcIdx <= '0;
            stepCnt <= '0;
            active <= 1'b0;
            dinoY <= groundY;
        end else if (running) begin
            if (!active) begin
                // Jump only from the ground, a press mid-arc is ignored
                if (jump && dinoY == groundY) begin
                    active <= 1'b1;
                    arcIdx <= '0;
                    stepCnt <= '0;
                end
            end else if (stepDone) begin
                stepCnt <= '0;
                // Last entry done, back to idle
                if (arcIdx == idxW'(jumpSteps - 1)) begin
                    active <= 1'b0;
                end else begin
                    arcIdx <= arcIdx + idxW'(1);
                end
            end else begin
                stepCnt <= stepCnt + stepW'(1);
            end
            // Elevation lifts the sprite, so it subtracts from Y
            dinoY <= groundY - (active ? jumpArc[arcIdx] : '0);
        end
        // Paused, the dino hangs where it is
    end

endmodule

// File: collisionDetector.sv
`timescale 1ns/10ps

module collisionDetector
    import dinoGeometryPkg::*;
    import dinoGameCtrlPkg::*;
#(
    parameter int numLanes = 2
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [stateW-1:0] gameState,
    input  logic [coordW-1:0] obsX [numLanes],
    input  logic [coordW-1:0] obsH [numLanes],
    input  logic [coordW-1:0] dinoY,
    output logic              collision
);

    // Overlap of any lane this cycle
    logic anyHit;

    always_comb begin
        anyHit = 1'b0;
        for (int i = 0; i < numLanes; i++) begin
            // Left edge of the obstacle before the dino's right edge
            // Right edge past the dino's left edge, 9 bits so X near 255 cannot wrap
            // Bottom of the dino below the obstacle's top
            if (obsX[i] < coordW'(dinoRight) &&
                    ({1'b0, obsX[i]} + 9'(obsW)) > 9'(dinoLeft) &&
                    ({1'b0, dinoY} + 9'(dinoH)) > (9'(groundTop) - {1'b0, obsH[i]})) begin
                anyHit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            collision <= 1'b0;
        end else if (gameState == gameRunning && anyHit) begin
            // Sticky until the next menu
            collision <= 1'b1;
        end
    end

endmodule

// File: scoreKeeper.sv
`timescale 1ns/10ps

module scoreKeeper
    import dinoGameCtrlPkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic [stateW-1:0] gameState,
    input  logic              moveTick,
    output logic [3:0]        scoreDigit [scoreDigits],
    output logic [speedW-1:0] speedLevel
);

    // Score plus one, computed every cycle
    logic [3:0] nextDigit [scoreDigits];

    always_comb begin
        logic carry;
        carry = 1'b1;
        for (int i = 0; i < scoreDigits; i++) begin
            if (carry && scoreDigit[i] == 4'd9) begin
                // Digit rolls over, carry moves up
                nextDigit[i] = 4'd0;
            end else if (carry) begin
                nextDigit[i] = scoreDigit[i] + 4'd1;
                carry = 1'b0;
            end else begin
                nextDigit[i] = scoreDigit[i];
            end
        end
        // A carry out of the top digit is dropped, 999999 wraps to 0
    end

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            for (int i = 0; i < scoreDigits; i++) begin
                scoreDigit[i] <= 4'd0;
            end
            speedLevel <= speedSlow;
        end else if (gameState == gameRunning) begin
            // One point per movement tick
            if (moveTick) begin
                scoreDigit <= nextDigit;
            end
            // Level follows the registered score, one cycle behind it
            if (scoreDigit[5] != 4'd0 || scoreDigit[4] != 4'd0) begin
                speedLevel <= speedFast;
            end else if (scoreDigit[3] != 4'd0) begin
                speedLevel <= speedMid;
            end else begin
                speedLevel <= speedSlow;
            end
        end
    end

endmodule

// File: dinoGameTop.sv
`timescale 1ns/10ps

module dinoGameTop
    import dinoGeometryPkg::*;
    import dinoGameCtrlPkg::*;
#(
    parameter int numLanes = 2,
    parameter int tickBase = 86654,
    parameter int jumpStepCycles = 137000
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              jump,
    input  logic [stateW-1:0] gameState,
    output logic [coordW-1:0] dinoY,
    output logic [coordW-1:0] obsX [numLanes],
    output logic [coordW-1:0] obsH [numLanes],
    output logic              collision,
    output logic [3:0]        scoreDigit [scoreDigits],
    output logic [speedW-1:0] speedLevel
);

    // Game-wide movement pulse
    logic moveTick;

    // Pace set by the score's speed level
    moveTicker #(
        .tickBase(tickBase)
    ) i_moveTicker (
        .clk(clk),
        .resetn(resetn),
        .gameState(gameState),
        .speedLevel(speedLevel),
        .moveTick(moveTick)
    );

    // One lane per obstacle, each with its own start entry and LFSR
    for (genvar g = 0; g < numLanes; g++) begin : genLane
        obstacleLane #(
            .laneIndex(g)
        ) i_obstacleLane (
            .clk(clk),
            .resetn(resetn),
            .gameState(gameState),
            .moveTick(moveTick),
            .obsX(obsX[g]),
            .obsH(obsH[g])
        );
    end

    jumpController #(
        .jumpStepCycles(jumpStepCycles)
    ) i_jumpController (
        .clk(clk),
        .resetn(resetn),
        .gameState(gameState),
        .jump(jump),
        .dinoY(dinoY)
    );

    // Sees every lane and the dino
    collisionDetector #(
        .numLanes(numLanes)
    ) i_collisionDetector (
        .clk(clk),
        .resetn(resetn),
        .gameState(gameState),
        .obsX(obsX),
        .obsH(obsH),
        .dinoY(dinoY),
        .collision(collision)
    );

    scoreKeeper i_scoreKeeper (
        .clk(clk),
        .resetn(resetn),
        .gameState(gameState),
        .moveTick(moveTick),
        .scoreDigit(scoreDigit),
        .speedLevel(speedLevel)
    );

endmodule

// File: dinoGameTb.sv
`timescale 1ns/10ps

module dinoGameTb
    import dinoGeometryPkg::*;
    import dinoGameCtrlPkg::*;
;

    localparam int numLanes = 2;
    localparam int tickBase = 4;
    localparam int jumpStepCycles = 3;
    localparam int groundY = groundTop - dinoH;

    // Stimulus table columns
    localparam int colState = 0;
    localparam int colJump = 1;
    localparam int colCycles = 2;
    localparam int colColl = 3;
    localparam int colPeriod = 4;
    localparam int numRows = 12;

    // State, jump mode, cycles, expected collision, tick period to measure (0 none)
    // State 1 runs and 0 is menu while 5, 9 and 15 pause
    localparam int stimTable [numRows][5] = '{
        '{0, 0, 5, 0, 0},
        '{1, 0, 120, 0, 0},
        '{5, 0, 30, 0, 0},
        '{1, 1, 400, 0, 0},
        '{9, 0, 20, 0, 0},
        '{1, 0, 3200, 1, 0},
        '{0, 0, 4, 0, 0},
        '{1, 0, 12100, 1, 0},
        '{1, 0, 800, 1, 8},
        '{15, 0, 10, 1, 0},
        '{0, 0, 5, 0, 0},
        '{1, 1, 200, 0, 0}
    };

    logic              clk;
    logic              resetn;
    logic              jump;
    logic [stateW-1:0] gameState;
    logic [coordW-1:0] dinoY;
    logic [coordW-1:0] obsX [numLanes];
    logic [coordW-1:0] obsH [numLanes];
    logic              collision;
    logic [3:0]        scoreDigit [scoreDigits];
    logic [speedW-1:0] speedLevel;

    // Reference model state
    int         mCnt;
    bit         mTick;
    int         mSpeed;
    int         mScore;
    int         mX [numLanes];
    int         mH [numLanes];
    logic [3:0] mLfsr [numLanes];
    bit         mActive;
    int         mIdx;
    int         mStep;
    int         mY;
    bit         mColl;

    logic [31:0] lcgState;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    dinoGameTop #(
        .numLanes(numLanes),
        .tickBase(tickBase),
        .jumpStepCycles(jumpStepCycles)
    ) i_dinoGameTop (
        .clk(clk),
        .resetn(resetn),
        .jump(jump),
        .gameState(gameState),
        .dinoY(dinoY),
        .obsX(obsX),
        .obsH(obsH),
        .collision(collision),
        .scoreDigit(scoreDigit),
        .speedLevel(speedLevel)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compareValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    // 4-bit height generator shifting in the inverted XOR of bits 2 and 0
    function automatic logic [3:0] lfsrStep(input logic [3:0] v);
        return {v[2:0], ~(v[2] ^ v[0])};
    endfunction

    function automatic int dutScore();
        int total;
        total = 0;
        for (int d = scoreDigits - 1; d >= 0; d--) begin
            total = total * 10 + int'(scoreDigit[d]);
        end
        return total;
    endfunction

    function automatic int tableCycles();
        int total;
        total = 0;
        for (int r = 0; r < numRows; r++) begin
            total += stimTable[r][colCycles];
        end
        return total;
    endfunction

    // One clock of the game rules
    task automatic stepModel();
        int period;
        bit tickNew;
        bit hit;
        int speedNew;
        int yNew;
        if (!resetn || gameState == gameMenu) begin
            mCnt = 0;
            mTick = 1'b0;
            mScore = 0;
            mSpeed = 1;
            mColl = 1'b0;
            mActive = 1'b0;
            mIdx = 0;
            mStep = 0;
            mY = groundY;
            for (int i = 0; i < numLanes; i++) begin
                mX[i] = int'(laneStartX[i]);
                mH[i] = int'(laneStartH[i]);
                mLfsr[i] = 4'd0;
            end
        end else if (gameState == gameRunning) begin
            // Overlap seen on this cycle's positions
            hit = 1'b0;
            for (int i = 0; i < numLanes; i++) begin
                if (mX[i] < dinoRight && mX[i] + obsW > dinoLeft &&
                        mY + dinoH > groundTop - mH[i]) begin
                    hit = 1'b1;
                end
            end
            if (hit) begin
                mColl = 1'b1;
            end
            // Tick period from the level in force
            period = tickBase * (4 - mSpeed);
            tickNew = (mCnt + 1 >= period);
            mCnt = tickNew ? 0 : mCnt + 1;
            // Level follows the score before this cycle's increment
            if (mScore >= 10000) begin
                speedNew = 3;
            end else if (mScore >= 1000) begin
                speedNew = 2;
            end else begin
                speedNew = 1;
            end
            // Score and lanes move on the cycle after a tick
            if (mTick) begin
                mScore = (mScore + 1) % 1000000;
                for (int i = 0; i < numLanes; i++) begin
                    if (mX[i] == 0) begin
                        mX[i] = spawnX;
                        mLfsr[i] = lfsrStep(mLfsr[i]);
                        mH[i] = minObsH + int'(mLfsr[i]);
                    end else begin
                        mX[i] = mX[i] - 1;
                    end
                end
            end
            mSpeed = speedNew;
            mTick = tickNew;
            // Registered elevation first and arc bookkeeping after it
            yNew = groundY - (mActive ? int'(jumpArc[mIdx]) : 0);
            if (!mActive) begin
                if (jump && mY == groundY) begin
                    mActive = 1'b1;
                    mIdx = 0;
                    mStep = 0;
                end
            end else if (mStep == jumpStepCycles - 1) begin
                mStep = 0;
                if (mIdx == jumpSteps - 1) begin
                    mActive = 1'b0;
                end else begin
                    mIdx = mIdx + 1;
                end
            end else begin
                mStep = mStep + 1;
            end
            mY = yNew;
        end
    endtask

    always @(posedge clk) begin
        stepModel();
    end

    // Run length guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: simulation ran past %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic checkOutputs();
        int pow10;
        compareValue("dinoY", int'(dinoY), mY);
        compareValue("collision", int'(collision), int'(mColl));
        compareValue("speedLevel", int'(speedLevel), mSpeed);
        for (int i = 0; i < numLanes; i++) begin
            compareValue($sformatf("obsX[%0d]", i), int'(obsX[i]), mX[i]);
            compareValue($sformatf("obsH[%0d]", i), int'(obsH[i]), mH[i]);
        end
        pow10 = 1;
        for (int d = 0; d < scoreDigits; d++) begin
            compareValue($sformatf("scoreDigit[%0d]", d), int'(scoreDigit[d]),
                (mScore / pow10) % 10);
            pow10 = pow10 * 10;
        end
    endtask

    // Values after reset or menu taken straight from the start tables
    task automatic checkStartValues();
        compareValue("dinoY", int'(dinoY), groundTop - dinoH);
        compareValue("collision", int'(collision), 0);
        compareValue("score", dutScore(), 0);
        compareValue("speedLevel", int'(speedLevel), 1);
        for (int i = 0; i < numLanes; i++) begin
            compareValue($sformatf("obsX[%0d]", i), int'(obsX[i]), int'(laneStartX[i]));
            compareValue($sformatf("obsH[%0d]", i), int'(obsH[i]), int'(laneStartH[i]));
        end
    endtask

    initial begin
        int state;
        int cycles;
        int nextJumpAt;
        int scoreBefore;
        int holdY;
        int holdColl;
        int holdSpeed;
        int holdX [numLanes];
        int holdH [numLanes];
        bit paused;
        resetn = 1'b0;
        jump = 1'b0;
        gameState = gameMenu;
        lcgState = 32'd85;
        cycleLimit = tableCycles() + 200;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        checkStartValues();
        checkOutputs();
        for (int r = 0; r < numRows; r++) begin
            state = stimTable[r][colState];
            cycles = stimTable[r][colCycles];
            gameState = stateW'(state);
            paused = (state != int'(gameMenu) && state != int'(gameRunning));
            // Snapshot for the paused hold check
            scoreBefore = dutScore();
            holdY = int'(dinoY);
            holdColl = int'(collision);
            holdSpeed = int'(speedLevel);
            for (int i = 0; i < numLanes; i++) begin
                holdX[i] = int'(obsX[i]);
                holdH[i] = int'(obsH[i]);
            end
            nextJumpAt = lcgNext() % 20;
            for (int c = 0; c < cycles; c++) begin
                // One-cycle presses that sometimes land mid-arc
                if (stimTable[r][colJump] == 1 && c == nextJumpAt) begin
                    jump = 1'b1;
                    nextJumpAt = c + 8 + lcgNext() % 50;
                end else begin
                    jump = 1'b0;
                end
                @(negedge clk);
                // Arc sampled once per step
                if (stimTable[r][colJump] == 1 && c % jumpStepCycles == 0) begin
                    compareValue("dinoY", int'(dinoY), mY);
                end
            end
            jump = 1'b0;
            checkOutputs();
            compareValue("collision", int'(collision), stimTable[r][colColl]);
            if (paused) begin
                compareValue("paused score", dutScore(), scoreBefore);
                compareValue("paused dinoY", int'(dinoY), holdY);
                compareValue("paused collision", int'(collision), holdColl);
                compareValue("paused speedLevel", int'(speedLevel), holdSpeed);
                for (int i = 0; i < numLanes; i++) begin
                    compareValue($sformatf("paused obsX[%0d]", i), int'(obsX[i]), holdX[i]);
                    compareValue($sformatf("paused obsH[%0d]", i), int'(obsH[i]), holdH[i]);
                end
            end
            if (state == int'(gameMenu)) begin
                checkStartValues();
            end
            // Ticks counted over a window at a steady level
            if (stimTable[r][colPeriod] != 0) begin
                compareValue("score ticks in window", dutScore() - scoreBefore,
                    cycles / stimTable[r][colPeriod]);
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: dinoGameTop.f
dinoGeometryPkg.sv
dinoGameCtrlPkg.sv
moveTicker.sv
obstacleLane.sv
jumpController.sv
collisionDetector.sv
scoreKeeper.sv
dinoGameTop.sv
dinoGameTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dinoGameTb \
    -f dinoGameTop.f -o dinoGameSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/dinoGameSim > sim.log 2>&1
cat sim.log

# Failure line anywhere in the log fails the run
grep -q "TESTS FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation passed"
exit 0
